// File: Makefile
TOP       ?= frontend_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+logic
logic/frontend_pkg.sv
logic/fetch_pc_gen.sv
logic/fetch_unit.sv
logic/multi_channel_fifo.sv
logic/inst_decoder.sv
logic/frontend.sv
verification/frontend_assertions.sv
verification/frontend_tb.sv

// File: logic/fetch_pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "frontend_macros.svh"

module fetch_pc_gen
    import frontend_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n_i,

    input  wire redirect_t   redirect_i,
    input  wire logic        advance_i,

    output logic [31:0]      block_pc_o,
    output logic             first_half_skip_o
);

    logic [31:0] block_pc;
    logic        skip_low;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            block_pc <= `FE_BOOT_PC;
            skip_low <= 1'b0;
        end else if (redirect_i.valid) begin
            // restart at the block holding the target
            block_pc <= {redirect_i.pc[31:3], 3'b000};
            skip_low <= redirect_i.pc[2];
        end else if (advance_i) begin
            block_pc <= block_pc + 32'd8;
            skip_low <= 1'b0;
        end
    end

    assign block_pc_o        = block_pc;
    assign first_half_skip_o = skip_low;

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "frontend_macros.svh"

module fetch_unit
    import frontend_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               arst_n_i,

    input  wire redirect_t          redirect_i,
    input  wire logic [31:0]        block_pc_i,
    input  wire logic               first_half_skip_i,
    output logic                    advance_o,

    output fetch_req_t              bus_req_o,
    input  wire logic               bus_req_ready_i,
    input  wire fetch_resp_t        bus_resp_i,

    input  wire logic [3:0]         fifo_free_i,
    output logic [1:0]              fifo_write_num_o,
    output fifo_entry_t [1:0]       fifo_write_data_o
);

    // one block per outstanding request, two FIFO entries each
    localparam int PEND_DEPTH = `FE_FIFO_DEPTH / 2;
    localparam int PTR_W      = $clog2(PEND_DEPTH);
    localparam int CNT_W      = $clog2(PEND_DEPTH + 1);

    typedef struct packed {
        logic [31:0] pc;
        logic        skip;
    } pend_t;

    pend_t            pend_mem [PEND_DEPTH];
    pend_t            head;
    logic [PTR_W-1:0] push_ptr;
    logic [PTR_W-1:0] pop_ptr;
    logic [CNT_W-1:0] out_cnt;
    logic [CNT_W-1:0] out_cnt_next;
    logic [CNT_W-1:0] stale_cnt;
    logic [3:0]       need;
    logic             started;
    logic             accept;
    logic             resp_live;

    // room for all outstanding blocks plus the new one
    assign need            = 4'({out_cnt, 1'b0}) + 4'd2;
    assign bus_req_o.valid = started && (need <= fifo_free_i);
    assign bus_req_o.addr  = block_pc_i;

    assign accept    = bus_req_o.valid && bus_req_ready_i;
    assign advance_o = accept;

    assign head         = pend_mem[pop_ptr];
    assign resp_live    = bus_resp_i.valid && (stale_cnt == '0);
    assign out_cnt_next = out_cnt + CNT_W'(accept) - CNT_W'(bus_resp_i.valid);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            started   <= 1'b0;
            push_ptr  <= '0;
            pop_ptr   <= '0;
            out_cnt   <= '0;
            stale_cnt <= '0;
        end else begin
            started <= 1'b1;
            out_cnt <= out_cnt_next;
            if (accept) begin
                push_ptr <= push_ptr + 1'b1;
            end
            if (bus_resp_i.valid) begin
                pop_ptr <= pop_ptr + 1'b1;
            end
            // everything still in flight belongs to the old path
            if (redirect_i.valid) begin
                stale_cnt <= out_cnt_next;
            end else if (bus_resp_i.valid && stale_cnt != '0) begin
                stale_cnt <= stale_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_mem[push_ptr] <= '{pc: block_pc_i, skip: first_half_skip_i};
        end
    end

    // lower instruction first, unless the block was entered mid-way
    always_comb begin
        fifo_write_data_o[1] = '{pc: head.pc + 32'd4, inst: bus_resp_i.data[63:32]};
        if (head.skip) begin
            fifo_write_data_o[0] = fifo_write_data_o[1];
            fifo_write_num_o     = 2'd1;
        end else begin
            fifo_write_data_o[0] = '{pc: head.pc, inst: bus_resp_i.data[31:0]};
            fifo_write_num_o     = 2'd2;
        end
        if (!resp_live) begin
            fifo_write_num_o = 2'd0;
        end
    end

endmodule

`default_nettype wire

// File: logic/frontend.sv
`timescale 1ns/10ps
`default_nettype none

`include "frontend_macros.svh"

module frontend
    import frontend_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          arst_n_i,

    input  wire redirect_t     redirect_i,

    output fetch_req_t         bus_req_o,
    input  wire logic          bus_req_ready_i,
    input  wire fetch_resp_t   bus_resp_i,

    output inst_t [1:0]        inst_o,
    output logic  [1:0]        inst_valid_o,
    input  wire logic [1:0]    credit_return_i
);

    localparam int CRED_W = $clog2(`FE_BACKEND_CREDITS + 1);

    logic [31:0]       block_pc;
    logic              first_half_skip;
    logic              advance;
    logic [1:0]        fifo_write_num;
    fifo_entry_t [1:0] fifo_write_data;
    fifo_entry_t [1:0] fifo_read_data;
    logic [3:0]        fifo_count;
    logic [3:0]        fifo_free;
    opcode_e [1:0]     dec_opcode;
    register_info_t [1:0] dec_reg_info;
    logic [CRED_W-1:0] credit_cnt;
    logic [3:0]        send_lim;
    logic [1:0]        send_num;

    fetch_pc_gen i_fetch_pc_gen (
        .clk,
        .arst_n_i,
        .redirect_i,
        .advance_i         (advance),
        .block_pc_o        (block_pc),
        .first_half_skip_o (first_half_skip)
    );

    fetch_unit i_fetch_unit (
        .clk,
        .arst_n_i,
        .redirect_i,
        .block_pc_i        (block_pc),
        .first_half_skip_i (first_half_skip),
        .advance_o         (advance),
        .bus_req_o,
        .bus_req_ready_i,
        .bus_resp_i,
        .fifo_free_i       (fifo_free),
        .fifo_write_num_o  (fifo_write_num),
        .fifo_write_data_o (fifo_write_data)
    );

    multi_channel_fifo #(
        .DATA_WIDTH ($bits(fifo_entry_t)),
        .DEPTH      (`FE_FIFO_DEPTH)
    ) i_inst_fifo (
        .clk,
        .arst_n_i,
        .flush_i      (redirect_i.valid),
        .write_num_i  (fifo_write_num),
        .write_data_i (fifo_write_data),
        .read_num_i   (send_num),
        .read_data_o  (fifo_read_data),
        .count_o      (fifo_count),
        .free_o       (fifo_free)
    );

    for (genvar i = 0; i < 2; i++) begin : g_dec
        inst_decoder i_inst_decoder (
            .inst_i          (fifo_read_data[i].inst),
            .opcode_o        (dec_opcode[i]),
            .register_info_o (dec_reg_info[i])
        );

        assign inst_o[i] = '{
            pc:            fifo_read_data[i].pc,
            inst:          fifo_read_data[i].inst,
            opcode:        dec_opcode[i],
            register_info: dec_reg_info[i]
        };
    end

    // min of occupancy, credits and two, nothing while redirecting
    always_comb begin
        send_lim = 4'd2;
        if (fifo_count < send_lim) begin
            send_lim = fifo_count;
        end
        if (4'(credit_cnt) < send_lim) begin
            send_lim = 4'(credit_cnt);
        end
        if (redirect_i.valid) begin
            send_lim = 4'd0;
        end
    end

    assign send_num     = send_lim[1:0];
    assign inst_valid_o = {send_num[1], send_num[1] | send_num[0]};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= CRED_W'(`FE_BACKEND_CREDITS);
        end else if (redirect_i.valid) begin
            // backend queue is emptied too, returns this cycle are void
            credit_cnt <= CRED_W'(`FE_BACKEND_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CRED_W'(send_num) + CRED_W'(credit_return_i);
        end
    end

endmodule

`default_nettype wire

// File: logic/frontend_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// first fetch block after reset
`define FE_BOOT_PC          32'h1c00_0000

// instruction FIFO entries, one instruction each
`define FE_FIFO_DEPTH       8

// backend queue capacity
`define FE_BACKEND_CREDITS  4

// opcode fields, see bit ranges per line
`define FE_OP_ADD_W         17'h00020
`define FE_OP_ADDI_W        10'h00a
`define FE_OP_LD_W          10'h0a2
`define FE_OP_ST_W          10'h0a6
`define FE_OP_BEQ           6'h16
`define FE_OP_BL            6'h15

`endif

// File: logic/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    typedef enum logic [2:0] {
        op_add,
        op_addi,
        op_load,
        op_store,
        op_beq,
        op_bl,
        op_invalid
    } opcode_e;

    // register number 0 means the slot is unused
    typedef struct packed {
        logic [1:0][4:0] r_reg;
        logic [4:0]      w_reg;
    } register_info_t;

    // one decoded instruction towards the backend
    typedef struct packed {
        logic [31:0]    pc;
        logic [31:0]    inst;
        opcode_e        opcode;
        register_info_t register_info;
    } inst_t;

    // instruction bus request, address is block aligned
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } fetch_req_t;

    // lower word holds the instruction at the lower address
    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } fetch_resp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    // instruction FIFO payload
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fifo_entry_t;

endpackage

`default_nettype wire

// File: logic/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "frontend_macros.svh"

module inst_decoder
    import frontend_pkg::*;
(
    input  wire logic [31:0] inst_i,
    output opcode_e          opcode_o,
    output register_info_t   register_info_o
);

    logic [4:0] rk;
    logic [4:0] rj;
    logic [4:0] rd;

    assign rk = inst_i[14:10];
    assign rj = inst_i[9:5];
    assign rd = inst_i[4:0];

    // opcode fields differ in length, longest match first
    always_comb begin
        if (inst_i[31:15] == `FE_OP_ADD_W) begin
            opcode_o = op_add;
        end else if (inst_i[31:22] == `FE_OP_ADDI_W) begin
            opcode_o = op_addi;
        end else if (inst_i[31:22] == `FE_OP_LD_W) begin
            opcode_o = op_load;
        end else if (inst_i[31:22] == `FE_OP_ST_W) begin
            opcode_o = op_store;
        end else if (inst_i[31:26] == `FE_OP_BEQ) begin
            opcode_o = op_beq;
        end else if (inst_i[31:26] == `FE_OP_BL) begin
            opcode_o = op_bl;
        end else begin
            opcode_o = op_invalid;
        end
    end

    always_comb begin
        register_info_o = '0;
        case (opcode_o)
            op_add: begin
                register_info_o.r_reg[0] = rk;
                register_info_o.r_reg[1] = rj;
                register_info_o.w_reg    = rd;
            end
            op_addi, op_load: begin
                register_info_o.r_reg[1] = rj;
                register_info_o.w_reg    = rd;
            end
            // rd is a source here, nothing is written
            op_store, op_beq: begin
                register_info_o.r_reg[0] = rd;
                register_info_o.r_reg[1] = rj;
            end
            // link register
            op_bl: begin
                register_info_o.w_reg = 5'd1;
            end
            default: begin
                register_info_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/multi_channel_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module multi_channel_fifo #(
    parameter int DATA_WIDTH = 64,
    parameter int DEPTH      = 8
) (
    input  wire logic                         clk,
    input  wire logic                         arst_n_i,
    input  wire logic                         flush_i,

    input  wire logic [1:0]                   write_num_i,
    input  wire logic [1:0][DATA_WIDTH-1:0]   write_data_i,

    input  wire logic [1:0]                   read_num_i,
    output logic [1:0][DATA_WIDTH-1:0]        read_data_o,

    output logic [3:0]                        count_o,
    output logic [3:0]                        free_o
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      wr_ptr_1;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      rd_ptr_1;
    logic [3:0]            count;

    // pointer advance, wraps modulo DEPTH
    function automatic logic [PTR_W-1:0] ptr_add(
        input logic [PTR_W-1:0] ptr,
        input logic [1:0]       inc
    );
        logic [PTR_W:0] sum;
        sum = {1'b0, ptr} + (PTR_W + 1)'(inc);
        if (sum >= (PTR_W + 1)'(DEPTH)) begin
            sum = sum - (PTR_W + 1)'(DEPTH);
        end
        return sum[PTR_W-1:0];
    endfunction

    assign wr_ptr_1 = ptr_add(wr_ptr, 2'd1);
    assign rd_ptr_1 = ptr_add(rd_ptr, 2'd1);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= ptr_add(wr_ptr, write_num_i);
            rd_ptr <= ptr_add(rd_ptr, read_num_i);
            count  <= count + 4'(write_num_i) - 4'(read_num_i);
        end
    end

    // writer only sends what fits
    always_ff @(posedge clk) begin
        if (!flush_i) begin
            if (write_num_i != 2'd0) begin
                mem[wr_ptr] <= write_data_i[0];
            end
            if (write_num_i[1]) begin
                mem[wr_ptr_1] <= write_data_i[1];
            end
        end
    end

    assign read_data_o[0] = mem[rd_ptr];
    assign read_data_o[1] = mem[rd_ptr_1];

    assign count_o = count;
    assign free_o  = 4'(DEPTH) - count;

endmodule

`default_nettype wire

// File: verification/frontend_assertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "frontend_macros.svh"

module frontend_assertions
    import frontend_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       arst_n_i,
    input  wire redirect_t  redirect_i,
    input  wire fetch_req_t req_i,
    input  wire logic       req_ready_i,
    input  wire logic [1:0] inst_valid_i,
    input  wire logic [$clog2(`FE_BACKEND_CREDITS + 1)-1:0] credit_cnt_i
);

    // slot 1 never valid without slot 0, and never more slots than credits
    thermo_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        (inst_valid_i != 2'b10) && ($countones(inst_valid_i) <= int'(credit_cnt_i)))
        else $error("inst_valid_o is not thermometer coded or exceeds the credits");

    req_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_i.valid |-> (req_i.addr[2:0] == 3'b000))
        else $error("bus request address is not 8-byte aligned");

    credit_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
        credit_cnt_i <= ($clog2(`FE_BACKEND_CREDITS + 1))'(`FE_BACKEND_CREDITS))
        else $error("credit counter above backend capacity");

    // a redirect may legally move a waiting request
    req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (req_i.valid && !req_ready_i && !redirect_i.valid)
            |=> (req_i.valid && $stable(req_i.addr)))
        else $error("bus request changed while waiting for ready");

endmodule

bind frontend frontend_assertions i_frontend_assertions (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .redirect_i   (redirect_i),
    .req_i        (bus_req_o),
    .req_ready_i  (bus_req_ready_i),
    .inst_valid_i (inst_valid_o),
    .credit_cnt_i (credit_cnt)
);

`default_nettype wire

// File: verification/frontend_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "frontend_macros.svh"

module frontend_tb
    import frontend_pkg::*;
();

    logic        clk = 1'b0;
    logic        arst_n_i;
    redirect_t   redirect_i;
    fetch_req_t  bus_req_o;
    logic        bus_req_ready_i;
    fetch_resp_t bus_resp_i;
    inst_t [1:0] inst_o;
    logic [1:0]  inst_valid_o;
    logic [1:0]  credit_return_i;

    logic [31:0] mem [256];
    logic [31:0] resp_addr_q [$];
    int          resp_due_q [$];
    int          cyc = 0;
    logic        hold_credits;
    int          held = 0;
    logic [31:0] exp_pc;
    int          in_flight = 0;
    int          issued_cnt = 0;
    int          since_redirect = 0;
    int          op_seen [7];
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          err_mark = 0;

    always #2 clk = ~clk;

    frontend i_frontend (
        .clk,
        .arst_n_i,
        .redirect_i,
        .bus_req_o,
        .bus_req_ready_i,
        .bus_resp_i,
        .inst_o,
        .inst_valid_o,
        .credit_return_i
    );

    // one of the six encodings or a word matching none of them
    function automatic logic [31:0] random_word();
        logic [31:0] r;
        logic [31:0] w;
        r = $urandom;
        case ($urandom % 7)
            0: w = {`FE_OP_ADD_W, r[14:0]};
            1: w = {`FE_OP_ADDI_W, r[21:0]};
            2: w = {`FE_OP_LD_W, r[21:0]};
            3: w = {`FE_OP_ST_W, r[21:0]};
            4: w = {`FE_OP_BEQ, r[25:0]};
            5: w = {`FE_OP_BL, r[25:0]};
            default: w = {6'h3f, r[25:0]};
        endcase
        return w;
    endfunction

    // expected decode, rk [14:10], rj [9:5], rd [4:0]
    function automatic inst_t ref_decode(input logic [31:0] pc, input logic [31:0] w);
        inst_t e;
        e        = '0;
        e.pc     = pc;
        e.inst   = w;
        e.opcode = op_invalid;
        if (w[31:15] == `FE_OP_ADD_W) e.opcode = op_add;
        else if (w[31:22] == `FE_OP_ADDI_W) e.opcode = op_addi;
        else if (w[31:22] == `FE_OP_LD_W) e.opcode = op_load;
        else if (w[31:22] == `FE_OP_ST_W) e.opcode = op_store;
        else if (w[31:26] == `FE_OP_BEQ) e.opcode = op_beq;
        else if (w[31:26] == `FE_OP_BL) e.opcode = op_bl;
        case (e.opcode)
            op_add: begin
                e.register_info.r_reg[0] = w[14:10];
                e.register_info.r_reg[1] = w[9:5];
                e.register_info.w_reg    = w[4:0];
            end
            op_addi, op_load: begin
                e.register_info.r_reg[1] = w[9:5];
                e.register_info.w_reg    = w[4:0];
            end
            op_store, op_beq: begin
                e.register_info.r_reg[0] = w[4:0];
                e.register_info.r_reg[1] = w[9:5];
            end
            op_bl: e.register_info.w_reg = 5'd1;
            default: e.register_info = '0;
        endcase
        return e;
    endfunction

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_opcode(input string name, input opcode_e got, input opcode_e exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_credits(input int count);
        if (count > `FE_BACKEND_CREDITS || count < 0) begin
            $display("ERR in_flight got %h limit %h", count, `FE_BACKEND_CREDITS);
            errors++;
        end
    endtask

    task automatic wait_for(input int goal, input bit after_redirect);
        for (int t = 0; t < 2000; t++) begin
            @(negedge clk);
            if ((after_redirect ? since_redirect : issued_cnt) >= goal) return;
        end
        $display("timeout while waiting for %0d issued instructions", goal);
        errors++;
    endtask

    task automatic wait_in_flight(input int goal);
        for (int t = 0; t < 2000; t++) begin
            @(negedge clk);
            if (in_flight == goal) return;
        end
        $display("timeout while waiting for %0d instructions in flight", goal);
        errors++;
    endtask

    task automatic send_redirect(input logic [31:0] target);
        @(posedge clk);
        redirect_i <= '{valid: 1'b1, pc: target};
        @(posedge clk);
        redirect_i <= '0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("test %0d %s: %0d error(s)", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    // in-order bus memory, 1 to 4 cycles of latency
    always @(posedge clk) begin : bus_model
        int          lat;
        logic [31:0] a;
        cyc++;
        bus_req_ready_i <= ($urandom % 4) != 0;
        if (bus_req_o.valid && bus_req_ready_i) begin
            lat = 1 + int'($urandom % 4);
            resp_addr_q.push_back(bus_req_o.addr);
            resp_due_q.push_back(cyc + lat - 1);
        end
        bus_resp_i <= '0;
        if (resp_due_q.size() != 0 && resp_due_q[0] <= cyc) begin
            a = resp_addr_q.pop_front();
            void'(resp_due_q.pop_front());
            bus_resp_i <= '{valid: 1'b1, data: {mem[{a[9:3], 1'b1}], mem[{a[9:3], 1'b0}]}};
        end
    end

    // backend queue, frees entries at random
    always @(posedge clk) begin : backend_model
        int ret_n;
        if (!arst_n_i || redirect_i.valid) held = 0;
        else held = held + int'(inst_valid_o[0]) + int'(inst_valid_o[1])
                    - int'(credit_return_i);
        ret_n = 0;
        if (!hold_credits && held > 0) begin
            ret_n = int'($urandom % 3);
            if (ret_n > held) ret_n = held;
        end
        credit_return_i <= 2'(ret_n);
    end

    always @(posedge clk) begin : compare_proc
        inst_t expected;
        int    n;
        if (!arst_n_i) begin
            exp_pc    = `FE_BOOT_PC;
            in_flight = 0;
        end else begin
            n = 0;
            for (int i = 0; i < 2; i++) begin
                if (inst_valid_o[i]) begin
                    expected = ref_decode(exp_pc, mem[exp_pc[9:2]]);
                    check_inst($sformatf("inst_o[%0d]", i), inst_o[i], expected);
                    check_opcode($sformatf("inst_o[%0d].opcode", i), inst_o[i].opcode,
                                 expected.opcode);
                    op_seen[int'(expected.opcode)]++;
                    // next pc in program order
                    exp_pc = exp_pc + 32'd4;
                    n++;
                end
            end
            issued_cnt     += n;
            since_redirect += n;
            if (redirect_i.valid) begin
                if (inst_valid_o !== 2'b00) begin
                    $display("ERR inst_valid_o got %h expected %h", inst_valid_o, 2'b00);
                    errors++;
                end
                exp_pc         = redirect_i.pc;
                since_redirect = 0;
                in_flight      = 0;
            end else begin
                in_flight = in_flight + n - int'(credit_return_i);
            end
            check_credits(in_flight);
        end
    end

    initial begin
        int          mark;
        logic [31:0] target;
        void'($urandom(79169));
        arst_n_i        = 1'b0;
        redirect_i      = '0;
        bus_req_ready_i = 1'b0;
        bus_resp_i      = '0;
        credit_return_i = 2'd0;
        hold_credits    = 1'b0;
        for (int a = 0; a < 256; a++) mem[a] = random_word();
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;

        wait_for(48, 1'b0);
        end_test("sequential fetch");

        @(posedge clk);
        hold_credits <= 1'b1;
        // a return already on its way lands in the next cycle
        @(posedge clk);
        wait_in_flight(`FE_BACKEND_CREDITS);
        mark = issued_cnt;
        repeat (8) @(negedge clk);
        if (in_flight != `FE_BACKEND_CREDITS || issued_cnt != mark) begin
            $display("issue did not stop at the credit limit while credits were withheld");
            errors++;
        end
        @(posedge clk);
        hold_credits <= 1'b0;
        wait_for(mark + 32, 1'b0);
        end_test("credit stall");

        send_redirect(`FE_BOOT_PC + 32'h100);
        wait_for(16, 1'b1);
        end_test("aligned redirect");

        send_redirect(`FE_BOOT_PC + 32'h204);
        wait_for(16, 1'b1);
        end_test("unaligned redirect");

        // redirect again while responses are still in flight
        repeat (6) begin
            target = `FE_BOOT_PC + (($urandom % 256) << 2);
            send_redirect(target);
            wait_for(1 + int'($urandom % 3), 1'b1);
        end
        wait_for(16, 1'b1);
        end_test("redirect in flight");

        for (int k = 0; k < 7; k++) begin
            if (op_seen[k] == 0) begin
                $display("opcode %0d was never issued", k);
                errors++;
            end
        end
        end_test("opcode mix");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) $display("Result: PASSED");
        else $display("Result: FAILED");
        $finish;
    end

    initial begin
        #500000;
        $display("simulation did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
